//--- source/armCore_defs.svh
`ifndef ARMCORE_DEFS_SVH
`define ARMCORE_DEFS_SVH

// Word and register file geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 4

// Unified RAM depth in words
`define MEM_WORDS 64

// R15 is the program counter
`define PC_REG 15

`endif

//--- source/armPkg.sv
`default_nettype none

package armPkg;

  // ALU operations understood by the datapath
  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOrr = 4'd3,
    aluEor = 4'd4,
    aluMul = 4'd5,
    aluMov = 4'd6,
    aluMvn = 4'd7
  } aluOp_t;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flags_t;

  // Field overlay of an instruction word, MUL layout for the low bits
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic [5:0] funct; // I, cmd, S
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] mop;
    logic [3:0] rm;
  } instr_t;

  // Per-state control word from the main FSM
  typedef struct packed {
    logic       nextPc;
    logic       branch;
    logic       regW;
    logic       memW;
    logic       irWrite;
    logic       adrSrc;
    logic       aluOp;
    logic [1:0] resultSrc;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
  } fsmCtrl_t;

  // Everything the datapath needs in one word
  typedef struct packed {
    logic       pcWrite;
    logic       regWrite;
    logic       irWrite;
    logic       adrSrc;
    logic       mulSrc;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic [1:0] resultSrc;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    aluOp_t     aluControl;
  } dpCtrl_t;

endpackage

`default_nettype wire

//--- source/alu.sv
`default_nettype none
`include "armCore_defs.svh"

module alu (
  input  wire [`DATA_WIDTH-1:0]  a,
  input  wire [`DATA_WIDTH-1:0]  b,
  input  wire armPkg::aluOp_t    op,
  output logic [`DATA_WIDTH-1:0] result,
  output armPkg::flags_t         flags
);
  import armPkg::*;

  logic                   isSub;
  logic [`DATA_WIDTH-1:0] bIn;
  logic [`DATA_WIDTH:0]   sum; // Extra bit is the carry out

  assign isSub = (op == aluSub);
  assign bIn   = isSub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bIn} + {{`DATA_WIDTH{1'b0}}, isSub};

  always_comb begin
    case (op)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      aluEor:  result = a ^ b;
      aluMul:  result = a * b; // Low word of the product
      aluMov:  result = b;
      aluMvn:  result = ~b;
      default: result = sum[`DATA_WIDTH-1:0];
    endcase
  end

  assign flags = '{
    neg:      result[`DATA_WIDTH-1],
    zero:     (result == '0),
    carry:    sum[`DATA_WIDTH],
    overflow: ~(a[`DATA_WIDTH-1] ^ b[`DATA_WIDTH-1] ^ isSub) &
              (a[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1])
  };

endmodule

`default_nettype wire

//--- source/mainFsm.sv
`default_nettype none

module mainFsm (
  input  wire                   clk,
  input  wire                   reset,
  input  wire armPkg::instr_t   instr,
  output armPkg::fsmCtrl_t      ctrl
);
  import armPkg::*;

  typedef enum logic [3:0] {
    fetch,
    decode,
    memAdr,
    memRd,
    memWb,
    memWr,
    executeR,
    executeI,
    aluWb,
    branch,
    unknown
  } state_t;

  state_t state;
  state_t nextState;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) state <= fetch;
    else       state <= nextState;
  end

  ////////////////////
  // Next state
  always_comb begin
    nextState = fetch;
    case (state)
      fetch:  nextState = decode;
      decode: begin
        case (instr.op)
          2'b00:   nextState = instr.funct[5] ? executeI : executeR;
          2'b01:   nextState = memAdr;
          2'b10:   nextState = branch;
          default: nextState = unknown;
        endcase
      end
      memAdr:   nextState = instr.funct[0] ? memRd : memWr; // L bit
      memRd:    nextState = memWb;
      executeR: nextState = aluWb;
      executeI: nextState = aluWb;
      default:  nextState = fetch; // memWb, memWr, aluWb, branch, unknown
    endcase
  end

  ////////////////////
  // Control word per state
  always_comb begin
    ctrl = '0;
    case (state)
      fetch: begin
        ctrl.irWrite   = 1'b1;
        ctrl.nextPc    = 1'b1;
        ctrl.aluSrcA   = 2'b01; // PC
        ctrl.aluSrcB   = 2'b10; // Constant 4
        ctrl.resultSrc = 2'b10;
      end
      decode: begin
        // PC+4 again so R15 reads as PC+8
        ctrl.aluSrcA   = 2'b01;
        ctrl.aluSrcB   = 2'b10;
        ctrl.resultSrc = 2'b10;
      end
      memAdr:   ctrl.aluSrcB = 2'b01; // Base plus offset
      memRd:    ctrl.adrSrc = 1'b1;
      memWb: begin
        ctrl.resultSrc = 2'b01; // Loaded word
        ctrl.regW      = 1'b1;
      end
      memWr: begin
        ctrl.adrSrc = 1'b1;
        ctrl.memW   = 1'b1;
      end
      executeR: ctrl.aluOp = 1'b1;
      executeI: begin
        ctrl.aluOp   = 1'b1;
        ctrl.aluSrcB = 2'b01;
      end
      aluWb:    ctrl.regW = 1'b1;
      branch: begin
        ctrl.branch    = 1'b1;
        ctrl.aluSrcB   = 2'b01;
        ctrl.resultSrc = 2'b10; // Target straight from the ALU
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`default_nettype none
`include "armCore_defs.svh"

module instrDecoder (
  input  wire armPkg::instr_t   instr,
  input  wire armPkg::fsmCtrl_t fsmCtrl,
  output logic [1:0]            flagW,
  output logic                  pcs,
  output armPkg::dpCtrl_t       decCtrl
);
  import armPkg::*;

  logic                       isMul;
  logic                       usesAdder;
  aluOp_t                     aluOp;
  logic [`REG_ADDR_WIDTH-1:0] dest;

  assign isMul = (instr.op == 2'b00) && !instr.funct[5] && (instr.mop == 4'b1001);

  // ALU decode from cmd, MUL overrides
  always_comb begin
    if (isMul) begin
      aluOp = aluMul;
    end else begin
      case (instr.funct[4:1])
        4'b0100: aluOp = aluAdd;
        4'b0010: aluOp = aluSub;
        4'b1010: aluOp = aluSub; // CMP
        4'b0000: aluOp = aluAnd;
        4'b1100: aluOp = aluOrr;
        4'b0001: aluOp = aluEor;
        4'b1101: aluOp = aluMov;
        4'b1111: aluOp = aluMvn;
        default: aluOp = aluAdd;
      endcase
    end
  end

  assign usesAdder = (aluOp == aluAdd) || (aluOp == aluSub);

  // N,Z on any S instruction, C,V only through the adder
  assign flagW[1] = fsmCtrl.aluOp & instr.funct[0];
  assign flagW[0] = fsmCtrl.aluOp & instr.funct[0] & usesAdder;

  // MUL writes the rn field
  assign dest = isMul ? instr.rn : instr.rd;
  assign pcs  = ((dest == `REG_ADDR_WIDTH'(`PC_REG)) & fsmCtrl.regW) | fsmCtrl.branch;

  assign decCtrl = '{
    pcWrite:    1'b0, // Filled in from condLogic
    regWrite:   1'b0,
    irWrite:    fsmCtrl.irWrite,
    adrSrc:     fsmCtrl.adrSrc,
    mulSrc:     isMul,
    regSrc:     {instr.op == 2'b01, instr.op == 2'b10},
    immSrc:     instr.op,
    resultSrc:  fsmCtrl.resultSrc,
    aluSrcA:    fsmCtrl.aluSrcA,
    aluSrcB:    fsmCtrl.aluSrcB,
    aluControl: fsmCtrl.aluOp ? aluOp : aluAdd
  };

endmodule

`default_nettype wire

//--- source/condLogic.sv
`default_nettype none

module condLogic (
  input  wire                 clk,
  input  wire                 reset,
  input  wire [3:0]           cond,
  input  wire armPkg::flags_t aluFlags,
  input  wire [1:0]           flagW,
  input  wire                 pcs,
  input  wire                 nextPc,
  input  wire                 regW,
  input  wire                 memW,
  output logic                pcWrite,
  output logic                regWrite,
  output logic                memWrite
);
  import armPkg::*;

  flags_t     flags;
  logic [1:0] flagWrite;
  logic       condEx;
  logic       condExReg; // Decision held for the write states
  logic       ge;

  assign flagWrite = flagW & {2{condEx}};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags     <= '0;
      condExReg <= 1'b0;
    end else begin
      if (flagWrite[1]) {flags.neg, flags.zero} <= {aluFlags.neg, aluFlags.zero};
      if (flagWrite[0]) {flags.carry, flags.overflow} <= {aluFlags.carry, aluFlags.overflow};
      condExReg <= condEx;
    end
  end

  ////////////////////
  // Condition check
  assign ge = (flags.neg == flags.overflow);

  always_comb begin
    case (cond)
      4'b0000: condEx = flags.zero;                 // EQ
      4'b0001: condEx = ~flags.zero;                // NE
      4'b0010: condEx = flags.carry;                // CS
      4'b0011: condEx = ~flags.carry;               // CC
      4'b0100: condEx = flags.neg;                  // MI
      4'b0101: condEx = ~flags.neg;                 // PL
      4'b0110: condEx = flags.overflow;             // VS
      4'b0111: condEx = ~flags.overflow;            // VC
      4'b1000: condEx = flags.carry & ~flags.zero;  // HI
      4'b1001: condEx = ~flags.carry | flags.zero;  // LS
      4'b1010: condEx = ge;
      4'b1011: condEx = ~ge;                        // LT
      4'b1100: condEx = ~flags.zero & ge;           // GT
      4'b1101: condEx = flags.zero | ~ge;           // LE
      4'b1110: condEx = 1'b1;                       // AL
      default: condEx = 1'b0;
    endcase
  end

  assign regWrite = regW & condExReg;
  assign memWrite = memW & condExReg;
  assign pcWrite  = (pcs & condExReg) | nextPc;

endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none
`include "armCore_defs.svh"

module datapath (
  input  wire                     clk,
  input  wire                     reset,
  input  wire armPkg::dpCtrl_t    ctrl,
  input  wire [`DATA_WIDTH-1:0]   readData,
  output logic [`DATA_WIDTH-1:0]  adr,
  output logic [`DATA_WIDTH-1:0]  writeData,
  output armPkg::instr_t          instr,
  output armPkg::flags_t          aluFlags
);
  import armPkg::*;

  localparam logic [`REG_ADDR_WIDTH-1:0] pcIdx = `REG_ADDR_WIDTH'(`PC_REG);

  logic [`DATA_WIDTH-1:0]     pc;
  logic [`DATA_WIDTH-1:0]     data;
  logic [`DATA_WIDTH-1:0]     aReg;
  logic [`DATA_WIDTH-1:0]     aluOut;
  logic [`DATA_WIDTH-1:0]     aluResult;
  logic [`DATA_WIDTH-1:0]     result;
  logic [`DATA_WIDTH-1:0]     srcA;
  logic [`DATA_WIDTH-1:0]     srcB;
  logic [`DATA_WIDTH-1:0]     extImm;
  logic [`DATA_WIDTH-1:0]     rd1;
  logic [`DATA_WIDTH-1:0]     rd2;
  logic [2*`DATA_WIDTH-1:0]   rotPair;
  logic [`REG_ADDR_WIDTH-1:0] ra1;
  logic [`REG_ADDR_WIDTH-1:0] ra2;
  logic [`REG_ADDR_WIDTH-1:0] wa;
  logic [`DATA_WIDTH-1:0]     regs [0:`PC_REG-1]; // R0..R14

  ////////////////////
  // PC and instruction
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc    <= '0;
      instr <= '0;
    end else begin
      if (ctrl.pcWrite) pc <= result;
      if (ctrl.irWrite) instr <= readData;
    end
  end

  assign adr = ctrl.adrSrc ? result : pc;

  // Stage registers load every cycle
  always_ff @(posedge clk) begin
    data      <= readData;
    aReg      <= rd1;
    writeData <= rd2;
    aluOut    <= aluResult;
  end

  ////////////////////
  // Register file
  assign ra1 = ctrl.regSrc[0] ? pcIdx : (ctrl.mulSrc ? instr.rm : instr.rn);
  assign ra2 = ctrl.regSrc[1] ? instr.rd : (ctrl.mulSrc ? instr.rs : instr.rm);
  assign wa  = ctrl.mulSrc ? instr.rn : instr.rd;

  always_ff @(posedge clk) begin
    if (ctrl.regWrite && wa != pcIdx) regs[wa] <= result;
  end

  // R15 returns the live result that holds PC+8 in decode
  assign rd1 = (ra1 == pcIdx) ? result : regs[ra1];
  assign rd2 = (ra2 == pcIdx) ? result : regs[ra2];

  ////////////////////
  // Immediate extend
  always_comb begin
    rotPair = {2{24'b0, instr[7:0]}} >> {instr[11:8], 1'b0};
    case (ctrl.immSrc)
      2'b00:   extImm = rotPair[`DATA_WIDTH-1:0];        // Rotated imm8
      2'b01:   extImm = {20'b0, instr[11:0]};            // LDR/STR offset
      default: extImm = {{6{instr[23]}}, instr[23:0], 2'b00}; // Branch
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcA)
      2'b01:   srcA = pc;
      default: srcA = aReg;
    endcase
    case (ctrl.aluSrcB)
      2'b01:   srcB = extImm;
      2'b10:   srcB = `DATA_WIDTH'(4);
      default: srcB = writeData;
    endcase
  end

  alu aluInst (
    .a      (srcA),
    .b      (srcB),
    .op     (ctrl.aluControl),
    .result (aluResult),
    .flags  (aluFlags)
  );

  always_comb begin
    case (ctrl.resultSrc)
      2'b01:   result = data;
      2'b10:   result = aluResult;
      default: result = aluOut;
    endcase
  end

endmodule

`default_nettype wire

//--- source/unifiedMemory.sv
`default_nettype none
`include "armCore_defs.svh"

module unifiedMemory (
  input  wire                    clk,
  input  wire                    we,
  input  wire [`DATA_WIDTH-1:0]  adr,
  input  wire [`DATA_WIDTH-1:0]  wd,
  input  wire                    loadEn,
  input  wire [`DATA_WIDTH-1:0]  loadAdr,
  input  wire [`DATA_WIDTH-1:0]  loadData,
  output logic [`DATA_WIDTH-1:0] rd
);

  localparam int idxWidth = $clog2(`MEM_WORDS);

  logic [`DATA_WIDTH-1:0] mem [0:`MEM_WORDS-1];
  logic [idxWidth-1:0]    coreIdx;
  logic [idxWidth-1:0]    loadIdx;

  // Byte addresses, word aligned
  assign coreIdx = adr[idxWidth+1:2];
  assign loadIdx = loadAdr[idxWidth+1:2];

  assign rd = mem[coreIdx]; // Asynchronous read

  always_ff @(posedge clk) begin
    if (loadEn)  mem[loadIdx] <= loadData; // Loader has priority
    else if (we) mem[coreIdx] <= wd;
  end

endmodule

`default_nettype wire

//--- source/armSystem.sv
`default_nettype none
`include "armCore_defs.svh"

module armSystem (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    loadEn,
  input  wire [`DATA_WIDTH-1:0]  loadAdr,
  input  wire [`DATA_WIDTH-1:0]  loadData,
  output logic                   memWrite,
  output logic [`DATA_WIDTH-1:0] dataAdr,
  output logic [`DATA_WIDTH-1:0] writeData
);
  import armPkg::*;

  instr_t                 instr;
  fsmCtrl_t               fsmCtrl;
  dpCtrl_t                decCtrl;
  dpCtrl_t                dpCtrl;
  flags_t                 aluFlags;
  logic [1:0]             flagW;
  logic                   pcs;
  logic                   pcWrite;
  logic                   regWrite;
  logic [`DATA_WIDTH-1:0] readData;

  mainFsm fsm (
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (fsmCtrl)
  );

  instrDecoder dec (
    .instr   (instr),
    .fsmCtrl (fsmCtrl),
    .flagW   (flagW),
    .pcs     (pcs),
    .decCtrl (decCtrl)
  );

  condLogic cl (
    .clk      (clk),
    .reset    (reset),
    .cond     (instr.cond),
    .aluFlags (aluFlags),
    .flagW    (flagW),
    .pcs      (pcs),
    .nextPc   (fsmCtrl.nextPc),
    .regW     (fsmCtrl.regW),
    .memW     (fsmCtrl.memW),
    .pcWrite  (pcWrite),
    .regWrite (regWrite),
    .memWrite (memWrite)
  );

  // Gated writes from condLogic, the rest from the decoder
  assign dpCtrl = '{
    pcWrite:    pcWrite,
    regWrite:   regWrite,
    irWrite:    decCtrl.irWrite,
    adrSrc:     decCtrl.adrSrc,
    mulSrc:     decCtrl.mulSrc,
    regSrc:     decCtrl.regSrc,
    immSrc:     decCtrl.immSrc,
    resultSrc:  decCtrl.resultSrc,
    aluSrcA:    decCtrl.aluSrcA,
    aluSrcB:    decCtrl.aluSrcB,
    aluControl: decCtrl.aluControl
  };

  datapath dp (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (dpCtrl),
    .readData  (readData),
    .adr       (dataAdr),
    .writeData (writeData),
    .instr     (instr),
    .aluFlags  (aluFlags)
  );

  // Program loading only while the core is held in reset
  unifiedMemory mem (
    .clk      (clk),
    .we       (memWrite),
    .adr      (dataAdr),
    .wd       (writeData),
    .loadEn   (loadEn & reset),
    .loadAdr  (loadAdr),
    .loadData (loadData),
    .rd       (readData)
  );

endmodule

`default_nettype wire

//--- verif/armTests.svh
`ifndef ARMTESTS_SVH
`define ARMTESTS_SVH

localparam logic [3:0] condEq = 4'h0;
localparam logic [3:0] condNe = 4'h1;
localparam logic [3:0] condCs = 4'h2;
localparam logic [3:0] condMi = 4'h4;
localparam logic [3:0] condLt = 4'hB;
localparam logic [3:0] condGt = 4'hC;
localparam logic [3:0] condAl = 4'hE;

localparam logic [3:0] cmdAnd = 4'b0000;
localparam logic [3:0] cmdEor = 4'b0001;
localparam logic [3:0] cmdSub = 4'b0010;
localparam logic [3:0] cmdAdd = 4'b0100;
localparam logic [3:0] cmdCmp = 4'b1010;
localparam logic [3:0] cmdOrr = 4'b1100;
localparam logic [3:0] cmdMov = 4'b1101;
localparam logic [3:0] cmdMvn = 4'b1111;

////////////////////
// Instruction encoders
function automatic logic [31:0] encodeDp(input logic [3:0] cond, input logic imm,
    input logic [3:0] cmd, input logic s, input logic [3:0] rn, input logic [3:0] rd,
    input logic [11:0] src2);
  return {cond, 2'b00, imm, cmd, s, rn, rd, src2};
endfunction

// Destination sits in bits 19:16
function automatic logic [31:0] encodeMul(input logic [3:0] rd, input logic [3:0] rs,
                                          input logic [3:0] rm);
  return {condAl, 8'b00000000, rd, 4'b0000, rs, 4'b1001, rm};
endfunction

// Pre-indexed with an added offset and no writeback
function automatic logic [31:0] encodeMem(input logic [3:0] cond, input logic load,
    input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
  return {cond, 2'b01, 4'b0110, 1'b0, load, rn, rd, offset};
endfunction

function automatic logic [31:0] encodeBranch(input logic [23:0] offset);
  return {condAl, 4'b1010, offset};
endfunction

function automatic logic [31:0] movImm(input logic [3:0] rd, input logic [7:0] imm);
  return encodeDp(condAl, 1'b1, cmdMov, 1'b0, 4'd0, rd, {4'b0, imm});
endfunction

// Flags of a - b by the ARM rules decide the condition
function automatic logic condHolds(input logic [3:0] cond, input logic [31:0] a,
                                   input logic [31:0] b);
  logic [31:0] res;
  logic        n;
  logic        z;
  logic        c;
  logic        v;
  res = a - b;
  n   = res[31];
  z   = (res == 0);
  c   = (a >= b); // No borrow
  v   = (a[31] != b[31]) && (res[31] != a[31]);
  case (cond)
    condEq:  return z;
    condNe:  return !z;
    condCs:  return c;
    condMi:  return n;
    condLt:  return n != v;
    condGt:  return !z && (n == v);
    default: return 1'b1;
  endcase
endfunction

////////////////////
// Directed tests
task automatic testDataProcessing();
  logic [31:0] r;
  logic [7:0]  immA;
  logic [7:0]  immB;
  logic [31:0] a;
  logic [31:0] b;
  logic [3:0]  cmdList [0:5];
  logic [31:0] expList [0:5];
  r    = randomWord();
  immA = r[7:0];
  r    = randomWord();
  immB = r[7:0];
  a    = {24'b0, immA};
  b    = {24'b0, immB};
  cmdList = '{cmdAdd, cmdSub, cmdAnd, cmdOrr, cmdEor, cmdMvn};
  expList = '{a + b, a - b, a & b, a | b, a ^ b, ~b};
  clearProgram();
  addWord(movImm(4'd1, immA));
  addWord(movImm(4'd2, immB));
  addWord(movImm(4'd3, 8'h80));
  for (int k = 0; k < 6; k++) begin
    addWord(encodeDp(condAl, 1'b0, cmdList[k], 1'b0, 4'd1, 4'd4, 12'd2)); // R4 = R1 op R2
    addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd4, 12'(4 * k)));
  end
  addWord(encodeBranch(24'hFFFFFE)); // Spin in place
  runProgram();
  for (int k = 0; k < 6; k++) begin
    expectStore("data processing", 32'h80 + 32'(4 * k), expList[k]);
  end
  expectQuiet("data processing", 60);
endtask

task automatic testMultiply();
  logic [31:0] r;
  logic [7:0]  immA;
  logic [7:0]  immB;
  logic [31:0] prod;
  r    = randomWord();
  immA = r[7:0];
  r    = randomWord();
  immB = r[7:0];
  prod = {24'b0, immA} * {24'b0, immB};
  clearProgram();
  addWord(movImm(4'd1, immA));
  addWord(movImm(4'd2, immB));
  addWord(movImm(4'd3, 8'h80));
  addWord(encodeMul(4'd4, 4'd2, 4'd1));
  addWord(encodeMul(4'd5, 4'd4, 4'd4)); // Square of the first product
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd4, 12'd0));
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd5, 12'd4));
  addWord(encodeBranch(24'hFFFFFE));
  runProgram();
  expectStore("mul", 32'h80, prod);
  expectStore("mul square", 32'h84, prod * prod);
  expectQuiet("mul", 60);
endtask

task automatic testLoadStore();
  logic [31:0] r;
  logic [7:0]  imm;
  r   = randomWord();
  imm = r[7:0];
  clearProgram();
  addWord(movImm(4'd1, imm));
  addWord(movImm(4'd3, 8'h80));
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd1, 12'd0));
  addWord(encodeMem(condAl, 1'b1, 4'd3, 4'd5, 12'd0)); // LDR R5
  addWord(encodeDp(condAl, 1'b1, cmdAdd, 1'b0, 4'd5, 4'd6, 12'd1));
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd6, 12'd4));
  addWord(encodeBranch(24'hFFFFFE));
  runProgram();
  expectStore("store", 32'h80, {24'b0, imm});
  expectStore("load back", 32'h84, {24'b0, imm} + 32'd1);
  expectQuiet("load store", 60);
endtask

task automatic runCondPair(input logic [7:0] immA, input logic invA, input logic [7:0] immB);
  logic [31:0] a;
  logic [31:0] b;
  logic [3:0]  condList [0:5];
  condList = '{condEq, condNe, condGt, condLt, condCs, condMi};
  a = invA ? ~{24'b0, immA} : {24'b0, immA};
  b = {24'b0, immB};
  clearProgram();
  addWord(encodeDp(condAl, 1'b1, invA ? cmdMvn : cmdMov, 1'b0, 4'd0, 4'd1, {4'b0, immA}));
  addWord(movImm(4'd2, immB));
  addWord(movImm(4'd3, 8'h80));
  addWord(encodeDp(condAl, 1'b0, cmdCmp, 1'b1, 4'd1, 4'd0, 12'd2));
  for (int k = 0; k < 6; k++) begin
    addWord(encodeMem(condList[k], 1'b0, 4'd3, 4'd1, 12'(4 * k)));
  end
  addWord(encodeBranch(24'hFFFFFE));
  runProgram();
  for (int k = 0; k < 6; k++) begin
    if (condHolds(condList[k], a, b)) begin
      expectStore("conditional", 32'h80 + 32'(4 * k), a);
    end
  end
  expectQuiet("conditional", 60);
endtask

task automatic testConditional();
  runCondPair(8'd7, 1'b0, 8'd7);
  runCondPair(8'd2, 1'b0, 8'd200);
  runCondPair(8'd200, 1'b0, 8'd2);
  runCondPair(8'd5, 1'b1, 8'd3); // Negative against positive
endtask

task automatic testBranch();
  clearProgram();
  addWord(movImm(4'd3, 8'h80));
  addWord(movImm(4'd1, 8'h5A));
  addWord(encodeBranch(24'h000000)); // Target PC+8 skips the marked store
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd1, 12'h010));
  addWord(encodeMem(condAl, 1'b0, 4'd3, 4'd1, 12'h014));
  addWord(encodeBranch(24'hFFFFFE));
  runProgram();
  expectStore("branch target", 32'h94, 32'h5A);
  expectQuiet("branch", 60);
endtask

task automatic testTiming();
  int   cycles;
  logic seen;
  cycles = 0;
  seen   = 1'b0;
  clearProgram();
  addWord(movImm(4'd1, 8'h80));
  addWord(encodeMem(condAl, 1'b0, 4'd1, 4'd1, 12'd0));
  addWord(encodeBranch(24'hFFFFFE));
  runProgram();
  while (!seen && cycles < storeTimeout) begin
    @(negedge clk);
    cycles++;
    if (memWrite === 1'b1) seen = 1'b1;
  end
  if (!seen) begin
    errors++;
    $display("No store seen in timing test within %0d cycles", storeTimeout);
  end else begin
    checkValue("timing cycle", 32'd8, 32'(cycles));
    checkValue("timing address", 32'h80, dataAdr);
    @(negedge clk);
    checkValue("timing width", 32'd0, {31'b0, memWrite});
  end
  expectQuiet("timing", 40);
endtask

`endif

//--- verif/armSystemTb.sv
`default_nettype none
`include "armCore_defs.svh"

module armSystemTb;

  localparam int storeTimeout = 300; // Cycles allowed between two stores

  logic                   clk;
  logic                   reset;
  logic                   loadEn;
  logic [`DATA_WIDTH-1:0] loadAdr;
  logic [`DATA_WIDTH-1:0] loadData;
  logic                   memWrite;
  logic [`DATA_WIDTH-1:0] dataAdr;
  logic [`DATA_WIDTH-1:0] writeData;

  logic [31:0] prog [0:`MEM_WORDS-1]; // Program image for the next run
  int          progLen;
  int          errors;
  int          checks;
  logic [31:0] seed;

  armSystem uut (
    .clk       (clk),
    .reset     (reset),
    .loadEn    (loadEn),
    .loadAdr   (loadAdr),
    .loadData  (loadData),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Helpers
  function automatic logic [31:0] randomWord();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Unused words decode as op 11, never reached by a correct run
  function automatic logic [31:0] fillWord(input int idx);
    return {8'hEC, 24'(idx) * 24'h041041};
  endfunction

  task automatic clearProgram();
    progLen = 0;
  endtask

  task automatic addWord(input logic [31:0] word);
    prog[progLen] = word;
    progLen++;
  endtask

  // Whole memory is rewritten under reset, then the core is released
  task automatic runProgram();
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      @(posedge clk);
      loadEn   <= 1'b1;
      loadAdr  <= 32'(i * 4);
      loadData <= (i < progLen) ? prog[i] : fillWord(i);
    end
    @(posedge clk);
    loadEn <= 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  // Samples on the falling edge, away from the DUT's updates
  task automatic waitStore(output logic seen, output logic [31:0] adr,
                           output logic [31:0] data);
    seen = 1'b0;
    adr  = '0;
    data = '0;
    for (int n = 0; n < storeTimeout && !seen; n++) begin
      @(negedge clk);
      if (memWrite === 1'b1) begin
        seen = 1'b1;
        adr  = dataAdr;
        data = writeData;
      end
    end
  endtask

  task automatic expectStore(input string testName, input logic [31:0] expAdr,
                             input logic [31:0] expData);
    logic        seen;
    logic [31:0] adr;
    logic [31:0] data;
    waitStore(seen, adr, data);
    if (!seen) begin
      errors++;
      $display("No store seen in %s within %0d cycles, expected address %h",
               testName, storeTimeout, expAdr);
    end else begin
      checkValue({testName, " address"}, expAdr, adr);
      checkValue({testName, " data"}, expData, data);
    end
  endtask

  task automatic expectQuiet(input string testName, input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (memWrite !== 1'b0) begin
        errors++;
        $display("Unexpected store in %s at address %h, data %h",
                 testName, dataAdr, writeData);
      end
    end
  endtask

  `include "armTests.svh"

  ////////////////////
  // Test sequence
  initial begin
    reset    = 1'b1;
    loadEn   = 1'b0;
    loadAdr  = '0;
    loadData = '0;
    errors   = 0;
    checks   = 0;
    progLen  = 0;
    seed     = 32'h855cda1d;
    repeat (4) @(posedge clk);
    testDataProcessing();
    testMultiply();
    testLoadStore();
    testConditional();
    testBranch();
    testTiming();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
+incdir+verif
source/armPkg.sv
source/alu.sv
source/mainFsm.sv
source/instrDecoder.sv
source/condLogic.sv
source/datapath.sv
source/unifiedMemory.sv
source/armSystem.sv
verif/armSystemTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = armSystemTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
